//--- common/hub_pkg.sv
`default_nettype none

package hub_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sizes.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int N_PORTS     = 4;
  localparam int PORT_W      = 2;
  localparam int FRAME_MAX   = 64;
  localparam int LEN_W       = 7;
  localparam int BUF_DEPTH   = 128;
  localparam int BUF_AW      = 7;
  localparam int FRAMES_MAX  = 4;
  localparam int Q_AW        = 2;
  localparam int IFG_DEFAULT = 12;
  localparam int CNT_W       = 16;
  localparam int CFG_W       = 16;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Line and configuration bus types.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic [7:0] data;
    logic       valid;
  } hub_byte_t;

  typedef struct packed {
    logic             write;
    logic [1:0]       addr;
    logic [CFG_W-1:0] wdata;
  } cfg_req_t;

  typedef struct packed {
    logic [CFG_W-1:0] rdata;
  } cfg_rsp_t;

  // Register map.
  localparam logic [1:0] REG_CTRL     = 2'd0;
  localparam logic [1:0] REG_IFG      = 2'd1;
  localparam logic [1:0] REG_FWD_CNT  = 2'd2;
  localparam logic [1:0] REG_DROP_CNT = 2'd3;

endpackage

`default_nettype wire

//--- hub/rx_frame_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module rx_frame_buffer (
  input  logic                      clk,
  input  logic                      rst,
  input  hub_pkg::hub_byte_t        rx,
  input  logic                      enable,
  input  logic                      pop,
  output logic                      frame_avail,
  output logic [hub_pkg::LEN_W-1:0] head_len,
  output logic [7:0]                head_byte,
  output logic                      drop
);

  logic [7:0]                 mem [hub_pkg::BUF_DEPTH];
  logic [hub_pkg::BUF_AW-1:0] wptr_com;
  logic [hub_pkg::BUF_AW-1:0] wptr_spec;
  logic [hub_pkg::BUF_AW-1:0] rptr;
  logic [hub_pkg::BUF_AW:0]   byte_cnt;

  logic [hub_pkg::LEN_W-1:0]  len_q [hub_pkg::FRAMES_MAX];
  logic [hub_pkg::Q_AW-1:0]   q_wr;
  logic [hub_pkg::Q_AW-1:0]   q_rd;
  logic [hub_pkg::Q_AW:0]     q_cnt;
  logic [hub_pkg::LEN_W-1:0]  rd_cnt;

  logic                       in_run;
  logic                       bad;
  logic [hub_pkg::LEN_W-1:0]  run_len;

  logic                       run_start;
  logic                       run_end;
  logic [hub_pkg::LEN_W-1:0]  len_next;
  logic                       bad_next;
  logic                       commit;
  logic                       pop_last;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Capture side.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    run_start = rx.valid && !in_run;
    run_end   = in_run && !rx.valid;
    len_next  = run_start ? hub_pkg::LEN_W'(1) : run_len + 1'b1;
    // A bad run stays bad until it ends.
    bad_next  = run_start ? !enable : bad;
    if (len_next > hub_pkg::LEN_W'(hub_pkg::FRAME_MAX)) begin
      bad_next = 1'b1;
    end
    if (({1'b0, len_next} + byte_cnt) > (hub_pkg::BUF_AW + 1)'(hub_pkg::BUF_DEPTH)) begin
      bad_next = 1'b1;
    end
    commit   = run_end && !bad && (q_cnt != (hub_pkg::Q_AW + 1)'(hub_pkg::FRAMES_MAX));
    pop_last = pop && ((rd_cnt + 1'b1) == head_len);
  end

  always_ff @(posedge clk) begin
    if (rx.valid && !bad_next) begin
      mem[wptr_spec] <= rx.data;
    end
    if (commit) begin
      len_q[q_wr] <= run_len;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      in_run    <= 1'b0;
      bad       <= 1'b0;
      run_len   <= '0;
      wptr_com  <= '0;
      wptr_spec <= '0;
      rptr      <= '0;
      rd_cnt    <= '0;
      byte_cnt  <= '0;
      q_wr      <= '0;
      q_rd      <= '0;
      q_cnt     <= '0;
      drop      <= 1'b0;
    end else begin
      in_run <= rx.valid;
      drop   <= run_end && !commit;
      if (rx.valid) begin
        run_len <= len_next;
        bad     <= bad_next;
        if (!bad_next) begin
          wptr_spec <= wptr_spec + 1'b1;
        end
      end
      // Commit the run, or roll the write pointer back.
      if (commit) begin
        wptr_com <= wptr_spec;
        q_wr     <= q_wr + 1'b1;
      end else if (run_end) begin
        wptr_spec <= wptr_com;
      end
      if (pop) begin
        rptr   <= rptr + 1'b1;
        rd_cnt <= pop_last ? '0 : rd_cnt + 1'b1;
        if (pop_last) begin
          q_rd <= q_rd + 1'b1;
        end
      end
      case ({commit, pop_last})
        2'b10:   q_cnt <= q_cnt + 1'b1;
        2'b01:   q_cnt <= q_cnt - 1'b1;
        default: q_cnt <= q_cnt;
      endcase
      byte_cnt <= byte_cnt + (commit ? {1'b0, run_len} : '0) - pop;
    end
  end

  // Read side, combinational toward the scheduler.
  assign frame_avail = (q_cnt != '0);
  assign head_len    = len_q[q_rd];
  assign head_byte   = mem[rptr];

  a_pop_avail: assert property (@(posedge clk) disable iff (rst) pop |-> frame_avail)
    else $error("pop while no frame is available");

endmodule

`default_nettype wire

//--- hub/flood_scheduler.sv
`timescale 1ns/100ps
`default_nettype none

module flood_scheduler (
  input  logic                                                clk,
  input  logic                                                rst,
  input  logic [hub_pkg::N_PORTS-1:0]                         frame_avail,
  input  logic [hub_pkg::N_PORTS-1:0][hub_pkg::LEN_W-1:0]     head_len,
  input  logic [hub_pkg::N_PORTS-1:0][7:0]                    head_byte,
  input  logic [hub_pkg::N_PORTS-1:0]                         port_en,
  input  logic [7:0]                                          ifg_ticks,
  output logic [hub_pkg::N_PORTS-1:0]                         pop,
  output hub_pkg::hub_byte_t [hub_pkg::N_PORTS-1:0]           tx,
  output logic                                                fwd_done
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_SEND,
    S_GAP
  } state_t;

  state_t                            state;
  logic [hub_pkg::PORT_W-1:0]        src;
  logic [hub_pkg::LEN_W-1:0]         byte_cnt;
  logic [7:0]                        gap_cnt;
  logic [hub_pkg::N_PORTS-1:0]       tx_vld;
  logic [7:0]                        tx_data;

  logic [hub_pkg::N_PORTS-1:0]       src_mask;
  logic [hub_pkg::PORT_W-1:0]        cand;
  logic [hub_pkg::PORT_W-1:0]        pick;
  logic                              pick_valid;
  logic                              last_byte;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Round-robin pick, starting after the last source.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    pick_valid = 1'b0;
    pick       = src;
    cand       = src;
    for (int i = 0; i < hub_pkg::N_PORTS; i++) begin
      cand = cand + 1'b1;
      if (!pick_valid && frame_avail[cand]) begin
        pick_valid = 1'b1;
        pick       = cand;
      end
    end
  end

  assign src_mask  = hub_pkg::N_PORTS'(1) << src;
  assign last_byte = ((byte_cnt + 1'b1) == head_len[src]);
  assign pop       = (state == S_SEND) ? src_mask : '0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Send FSM.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= S_IDLE;
      src      <= hub_pkg::PORT_W'(hub_pkg::N_PORTS - 1);
      byte_cnt <= '0;
      gap_cnt  <= '0;
      tx_vld   <= '0;
      fwd_done <= 1'b0;
    end else begin
      tx_vld   <= '0;
      fwd_done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (pick_valid) begin
            src      <= pick;
            byte_cnt <= '0;
            state    <= S_SEND;
          end
        end
        S_SEND: begin
          // Flood to every enabled port except the source.
          tx_vld   <= port_en & ~src_mask;
          byte_cnt <= byte_cnt + 1'b1;
          if (last_byte) begin
            fwd_done <= 1'b1;
            gap_cnt  <= ifg_ticks;
            state    <= S_GAP;
          end
        end
        S_GAP: begin
          if (gap_cnt == '0) begin
            state <= S_IDLE;
          end else begin
            gap_cnt <= gap_cnt - 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_SEND) begin
      tx_data <= head_byte[src];
    end
  end

  // Same byte on every lane, valid per lane.
  always_comb begin
    for (int i = 0; i < hub_pkg::N_PORTS; i++) begin
      tx[i].data  = tx_data;
      tx[i].valid = tx_vld[i];
    end
  end

  a_no_echo: assert property (@(posedge clk) disable iff (rst) !tx[src].valid)
    else $error("frame echoed back to its source port");

endmodule

`default_nettype wire

//--- hub/hub_config_regs.sv
`timescale 1ns/100ps
`default_nettype none

module hub_config_regs (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        cfg_valid,
  input  hub_pkg::cfg_req_t           cfg_req,
  output logic                        cfg_ready,
  output logic                        rsp_valid,
  output hub_pkg::cfg_rsp_t           cfg_rsp,
  input  logic                        fwd_done,
  input  logic [hub_pkg::N_PORTS-1:0] drop,
  output logic [hub_pkg::N_PORTS-1:0] port_en,
  output logic [7:0]                  ifg_ticks
);

  logic [hub_pkg::CNT_W-1:0]  fwd_cnt;
  logic [hub_pkg::CNT_W-1:0]  drop_cnt;
  logic [hub_pkg::PORT_W:0]   drop_sum;
  logic [hub_pkg::CNT_W:0]    drop_total;
  logic [hub_pkg::CFG_W-1:0]  rdata;

  // No wait states.
  assign cfg_ready = 1'b1;

  always_comb begin
    drop_sum = '0;
    for (int i = 0; i < hub_pkg::N_PORTS; i++) begin
      drop_sum = drop_sum + drop[i];
    end
    drop_total = {1'b0, drop_cnt} + (hub_pkg::CNT_W + 1)'(drop_sum);
  end

  always_comb begin
    case (cfg_req.addr)
      hub_pkg::REG_CTRL:    rdata = hub_pkg::CFG_W'(port_en);
      hub_pkg::REG_IFG:     rdata = hub_pkg::CFG_W'(ifg_ticks);
      hub_pkg::REG_FWD_CNT: rdata = fwd_cnt;
      default:              rdata = drop_cnt;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      port_en   <= '1;
      ifg_ticks <= 8'(hub_pkg::IFG_DEFAULT);
      fwd_cnt   <= '0;
      drop_cnt  <= '0;
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= cfg_valid && !cfg_req.write;
      if (cfg_valid && cfg_req.write) begin
        case (cfg_req.addr)
          hub_pkg::REG_CTRL: port_en   <= cfg_req.wdata[hub_pkg::N_PORTS-1:0];
          hub_pkg::REG_IFG:  ifg_ticks <= cfg_req.wdata[7:0];
          default:           port_en   <= port_en;
        endcase
      end
      // Counters saturate.
      if (fwd_done && (fwd_cnt != '1)) begin
        fwd_cnt <= fwd_cnt + 1'b1;
      end
      drop_cnt <= drop_total[hub_pkg::CNT_W] ? '1 : drop_total[hub_pkg::CNT_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (cfg_valid && !cfg_req.write) begin
      cfg_rsp.rdata <= rdata;
    end
  end

endmodule

`default_nettype wire

//--- hub/frame_hub.sv
`timescale 1ns/100ps
`default_nettype none

module frame_hub (
  input  logic                                      clk,
  input  logic                                      rst,
  input  hub_pkg::hub_byte_t [hub_pkg::N_PORTS-1:0] rx,
  output hub_pkg::hub_byte_t [hub_pkg::N_PORTS-1:0] tx,
  input  logic                                      cfg_valid,
  input  hub_pkg::cfg_req_t                         cfg_req,
  output logic                                      cfg_ready,
  output logic                                      rsp_valid,
  output hub_pkg::cfg_rsp_t                         cfg_rsp
);

  logic [hub_pkg::N_PORTS-1:0]                     frame_avail;
  logic [hub_pkg::N_PORTS-1:0][hub_pkg::LEN_W-1:0] head_len;
  logic [hub_pkg::N_PORTS-1:0][7:0]                head_byte;
  logic [hub_pkg::N_PORTS-1:0]                     pop;
  logic [hub_pkg::N_PORTS-1:0]                     drop;
  logic [hub_pkg::N_PORTS-1:0]                     port_en;
  logic [7:0]                                      ifg_ticks;
  logic                                            fwd_done;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // One receive buffer per line port.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar p = 0; p < hub_pkg::N_PORTS; p++) begin : g_port
    rx_frame_buffer rx_buf_i (
      .clk         (clk),
      .rst         (rst),
      .rx          (rx[p]),
      .enable      (port_en[p]),
      .pop         (pop[p]),
      .frame_avail (frame_avail[p]),
      .head_len    (head_len[p]),
      .head_byte   (head_byte[p]),
      .drop        (drop[p])
    );
  end

  flood_scheduler sched_i (
    .clk         (clk),
    .rst         (rst),
    .frame_avail (frame_avail),
    .head_len    (head_len),
    .head_byte   (head_byte),
    .port_en     (port_en),
    .ifg_ticks   (ifg_ticks),
    .pop         (pop),
    .tx          (tx),
    .fwd_done    (fwd_done)
  );

  hub_config_regs regs_i (
    .clk       (clk),
    .rst       (rst),
    .cfg_valid (cfg_valid),
    .cfg_req   (cfg_req),
    .cfg_ready (cfg_ready),
    .rsp_valid (rsp_valid),
    .cfg_rsp   (cfg_rsp),
    .fwd_done  (fwd_done),
    .drop      (drop),
    .port_en   (port_en),
    .ifg_ticks (ifg_ticks)
  );

endmodule

`default_nettype wire

//--- testbench/tb_hub_checks.svh
`ifndef TB_HUB_CHECKS_SVH
`define TB_HUB_CHECKS_SVH

// Where a frame must go, and whether it is dropped.
typedef struct packed {
  logic                        dropped;
  logic [hub_pkg::N_PORTS-1:0] dest;
} dest_t;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model of the forwarding rule.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
function automatic dest_t expected_dest(input int src, input int len,
                                        input logic [hub_pkg::N_PORTS-1:0] en);
  dest_t r;
  r.dropped = (len > hub_pkg::FRAME_MAX) || !en[src];
  // Flooded to all enabled ports but the source.
  r.dest    = r.dropped ? '0 : (en & ~(hub_pkg::N_PORTS'(1) << src));
  return r;
endfunction

task automatic check_byte(input string name, input hub_pkg::hub_byte_t got,
                          input hub_pkg::hub_byte_t exp);
  if (got !== exp) begin
    $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
    err_cnt++;
  end
endtask

task automatic check_frame_len(input string name, input logic [hub_pkg::LEN_W-1:0] got,
                               input logic [hub_pkg::LEN_W-1:0] exp);
  if (got !== exp) begin
    $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
    err_cnt++;
  end
endtask

task automatic check_cfg_rsp(input string name, input hub_pkg::cfg_rsp_t got,
                             input hub_pkg::cfg_rsp_t exp);
  if (got !== exp) begin
    $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got.rdata, exp.rdata);
    err_cnt++;
  end
endtask

`endif

//--- testbench/tb_frame_hub.sv
`timescale 1ns/100ps
`default_nettype none

module tb_frame_hub;

  localparam int IFG_TEST        = 20;
  localparam int FRAMES_SENT     = 9;
  localparam int WATCHDOG_CYCLES =
    2 * FRAMES_SENT * (hub_pkg::FRAME_MAX + 2 * IFG_TEST + 8) + 200;

  logic                                      clk = 1'b0;
  logic                                      rst;
  hub_pkg::hub_byte_t [hub_pkg::N_PORTS-1:0] rx;
  hub_pkg::hub_byte_t [hub_pkg::N_PORTS-1:0] tx;
  logic                                      cfg_valid;
  hub_pkg::cfg_req_t                         cfg_req;
  logic                                      cfg_ready;
  logic                                      rsp_valid;
  hub_pkg::cfg_rsp_t                         cfg_rsp;

  int seed          = 32'h6fb0;
  int err_cnt       = 0;
  int tests_run     = 0;
  int tests_failed  = 0;
  int test_err_base = 0;
  int min_gap       = hub_pkg::IFG_DEFAULT;
  int fwd_exp       = 0;
  int drop_exp      = 0;
  logic [hub_pkg::N_PORTS-1:0] en_model = '1;

  logic [7:0]         frame_buf [hub_pkg::N_PORTS][128];
  hub_pkg::hub_byte_t got_bytes [hub_pkg::N_PORTS][$];
  int                 got_lens  [hub_pkg::N_PORTS][$];
  hub_pkg::hub_byte_t exp_bytes [hub_pkg::N_PORTS][$];
  int                 exp_lens  [hub_pkg::N_PORTS][$];

  `include "tb_hub_checks.svh"

  frame_hub frame_hub_i (
    .clk       (clk),
    .rst       (rst),
    .rx        (rx),
    .tx        (tx),
    .cfg_valid (cfg_valid),
    .cfg_req   (cfg_req),
    .cfg_ready (cfg_ready),
    .rsp_valid (rsp_valid),
    .cfg_rsp   (cfg_rsp)
  );

  always #5 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus helpers.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic int random_len();
    return 2 + ({$random(seed)} % (hub_pkg::FRAME_MAX - 1));
  endfunction

  // Same length on every port in the mask, fresh random data each.
  task automatic drive_frames(input logic [hub_pkg::N_PORTS-1:0] mask, input int len);
    for (int i = 0; i < len; i++) begin
      @(posedge clk);
      for (int p = 0; p < hub_pkg::N_PORTS; p++) begin
        if (mask[p]) begin
          frame_buf[p][i] = 8'($random(seed));
          rx[p] <= '{data: frame_buf[p][i], valid: 1'b1};
        end
      end
    end
    @(posedge clk);
    rx <= '0;
    @(posedge clk);
  endtask

  task automatic expect_frame(input int src, input int len);
    dest_t              d;
    hub_pkg::hub_byte_t b;
    d = expected_dest(src, len, en_model);
    if (d.dropped) begin
      drop_exp++;
    end else begin
      fwd_exp++;
    end
    for (int p = 0; p < hub_pkg::N_PORTS; p++) begin
      if (d.dest[p]) begin
        for (int i = 0; i < len; i++) begin
          b.data  = frame_buf[src][i];
          b.valid = 1'b1;
          exp_bytes[p].push_back(b);
        end
        exp_lens[p].push_back(len);
      end
    end
  endtask

  // Waits until every expected frame is seen, then lets the gap run out.
  task automatic wait_drained();
    int pending;
    do begin
      @(posedge clk);
      pending = 0;
      for (int p = 0; p < hub_pkg::N_PORTS; p++) begin
        pending += exp_lens[p].size();
      end
    end while (pending != 0);
    repeat (min_gap + 4) @(posedge clk);
  endtask

  task automatic cfg_write(input logic [1:0] addr, input logic [15:0] data);
    @(posedge clk);
    cfg_valid <= 1'b1;
    cfg_req   <= '{write: 1'b1, addr: addr, wdata: data};
    do begin
      @(posedge clk);
    end while (!cfg_ready);
    cfg_valid <= 1'b0;
  endtask

  task automatic cfg_read(input logic [1:0] addr, output hub_pkg::cfg_rsp_t rsp);
    int waited;
    @(posedge clk);
    cfg_valid <= 1'b1;
    cfg_req   <= '{write: 1'b0, addr: addr, wdata: '0};
    do begin
      @(posedge clk);
    end while (!cfg_ready);
    cfg_valid <= 1'b0;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!rsp_valid && waited < 8);
    if (!rsp_valid) begin
      $display("no read response for register %0d", addr);
      err_cnt++;
    end
    rsp = cfg_rsp;
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (err_cnt == test_err_base) begin
      $display("test %-24s ok", name);
    end else begin
      tests_failed++;
      $display("test %-24s failed with %0d errors", name, err_cnt - test_err_base);
    end
    test_err_base = err_cnt;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Monitors and compare.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar p = 0; p < hub_pkg::N_PORTS; p++) begin : g_mon
    int   run_len = 0;
    int   idle    = 0;
    logic seen    = 1'b0;

    always @(posedge clk) begin
      if (rst) begin
        run_len = 0;
        idle    = 0;
        seen    = 1'b0;
      end else if (tx[p].valid) begin
        if (run_len == 0 && seen && idle < min_gap) begin
          $display("tx port %0d was idle %0d cycles between frames, less than %0d",
                   p, idle, min_gap);
          err_cnt++;
        end
        got_bytes[p].push_back(tx[p]);
        run_len++;
      end else begin
        if (run_len != 0) begin
          got_lens[p].push_back(run_len);
          run_len = 0;
          seen    = 1'b1;
          idle    = 0;
        end
        idle++;
      end
    end
  end

  task automatic compare_run(input int p);
    int                 glen;
    int                 elen;
    hub_pkg::hub_byte_t g;
    hub_pkg::hub_byte_t e;
    glen = got_lens[p].pop_front();
    elen = 0;
    if (exp_lens[p].size() == 0) begin
      $display("tx port %0d sent a frame of %0d bytes that was not expected there", p, glen);
      err_cnt++;
    end else begin
      elen = exp_lens[p].pop_front();
      check_frame_len($sformatf("tx[%0d] frame length", p),
                      hub_pkg::LEN_W'(glen), hub_pkg::LEN_W'(elen));
    end
    for (int i = 0; i < glen; i++) begin
      g = got_bytes[p].pop_front();
      if (i < elen) begin
        e = exp_bytes[p].pop_front();
        check_byte($sformatf("tx[%0d] byte %0d", p, i), g, e);
      end
    end
    for (int i = glen; i < elen; i++) begin
      e = exp_bytes[p].pop_front();
    end
  endtask

  always @(posedge clk) begin
    for (int p = 0; p < hub_pkg::N_PORTS; p++) begin
      while (got_lens[p].size() != 0) begin
        compare_run(p);
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Tests.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic single_frame_flood();
    int len;
    len = random_len();
    drive_frames(4'b0001, len);
    expect_frame(0, len);
    wait_drained();
    report_test("single frame flood");
  endtask

  // Last source was port 0, so port 1 goes before port 2.
  task automatic simultaneous_frames();
    int len;
    len = random_len();
    drive_frames(4'b0110, len);
    expect_frame(1, len);
    expect_frame(2, len);
    wait_drained();
    report_test("simultaneous frames");
  endtask

  task automatic gap_after_ifg_write();
    hub_pkg::cfg_rsp_t rsp;
    hub_pkg::cfg_rsp_t exp;
    int                len;
    cfg_write(hub_pkg::REG_IFG, 16'(IFG_TEST));
    min_gap = IFG_TEST;
    cfg_read(hub_pkg::REG_IFG, rsp);
    exp.rdata = 16'(IFG_TEST);
    check_cfg_rsp("cfg_rsp.rdata ifg", rsp, exp);
    len = random_len();
    // Search starts after port 2, so port 3 leads.
    drive_frames(4'b1001, len);
    expect_frame(3, len);
    expect_frame(0, len);
    wait_drained();
    report_test("gap after ifg write");
  endtask

  task automatic disabled_port();
    int len;
    cfg_write(hub_pkg::REG_CTRL, 16'h0007);
    en_model = 4'b0111;
    len = random_len();
    drive_frames(4'b1010, len);
    expect_frame(3, len);
    expect_frame(1, len);
    wait_drained();
    report_test("disabled port");
  endtask

  task automatic oversize_and_counters();
    hub_pkg::cfg_rsp_t rsp;
    hub_pkg::cfg_rsp_t exp;
    int                len;
    cfg_write(hub_pkg::REG_CTRL, 16'h000f);
    en_model = '1;
    drive_frames(4'b0100, hub_pkg::FRAME_MAX + 6);
    expect_frame(2, hub_pkg::FRAME_MAX + 6);
    len = random_len();
    drive_frames(4'b0001, len);
    expect_frame(0, len);
    wait_drained();
    cfg_read(hub_pkg::REG_FWD_CNT, rsp);
    exp.rdata = 16'(fwd_exp);
    check_cfg_rsp("cfg_rsp.rdata fwd count", rsp, exp);
    cfg_read(hub_pkg::REG_DROP_CNT, rsp);
    exp.rdata = 16'(drop_exp);
    check_cfg_rsp("cfg_rsp.rdata drop count", rsp, exp);
    report_test("oversize and counters");
  endtask

  initial begin
    rst       = 1'b1;
    rx        = '0;
    cfg_valid = 1'b0;
    cfg_req   = '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    single_frame_flood();
    simultaneous_frames();
    gap_after_ifg_write();
    disabled_port();
    oversize_and_counters();
    // Bytes still queued here belong to a run that never ended or never matched.
    for (int p = 0; p < hub_pkg::N_PORTS; p++) begin
      if (got_bytes[p].size() != 0 || got_lens[p].size() != 0) begin
        $display("frames left unmatched on tx port %0d", p);
        err_cnt++;
      end
    end
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0 && tests_failed == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Watchdog.
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- frame_hub.f
+incdir+testbench
common/hub_pkg.sv
hub/rx_frame_buffer.sv
hub/flood_scheduler.sv
hub/hub_config_regs.sv
hub/frame_hub.sv
testbench/tb_frame_hub.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the frame_hub testbench with Verilator and runs it.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f frame_hub.f --top-module tb_frame_hub -o sim_frame_hub

./obj_dir/sim_frame_hub | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation log in sim.log"
